/* compile.f */
design/fetch_pkg.sv
design/predecode.sv
design/line_refill.sv
design/icache_arrays.sv
design/fetch_ctrl.sv
design/fetch_queue.sv
design/fetch_unit.sv
tb/tb_clock.sv
tb/fetch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module fetch_unit_tb -f compile.f -o fetch_unit_sim

./obj_dir/fetch_unit_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log
then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tb/fetch_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb import fetch_pkg::*;
();

   localparam int SETS_LG = DEF_LG_NUM_SETS;
   localparam int FQ_LG = DEF_LG_FQ_ENTRIES;
   localparam int NUM_SETS = 1 << SETS_LG;
   localparam int TAG_BITS = 32 - SETS_LG - LG_LINE_BYTES;
   localparam int RANDOM_SEED = 85175;
   localparam int LOOKAHEAD = 16;     // instructions fetched past the last pop
   localparam int STALL_CYCLES = 20;
   localparam int WAIT_LIMIT = 200;

   typedef enum logic [1:0] {K_ADDI, K_J, K_JAL, K_BEQ} kind_t;
   typedef enum logic [1:0] {POP_SINGLE, POP_DUAL, POP_STALL} pop_mode_t;

   typedef struct packed {
      addr_t     pc;
      logic [7:0] count;
      pop_mode_t mode;
      logic      flush;
   } row_t;

   // program words that are not an addi
   localparam int N_PROG = 7;
   localparam addr_t PROG_ADDR [N_PROG] = '{32'h100c, 32'h1038, 32'h1044, 32'h1080,
                                           32'h1118, 32'h1208, 32'h1210};
   localparam kind_t PROG_KIND [N_PROG] = '{K_J, K_BEQ, K_JAL, K_JAL, K_J, K_BEQ, K_J};
   localparam int PROG_IMM [N_PROG] = '{32'sh24, 32'sh40, 32'sh1bc, 32'sh80, 32'sh8,
                                       -32'sh8, -32'sh1fc};

   // restart pc, pops, pop mode, flush first
   localparam int N_ROWS = 8;
   localparam row_t ROWS [N_ROWS] = '{
      '{32'h1000, 8'd12, POP_SINGLE, 1'b0},
      '{32'h1070, 8'd10, POP_DUAL,   1'b0},
      '{32'h1000, 8'd16, POP_STALL,  1'b0},
      '{32'h1100, 8'd10, POP_SINGLE, 1'b1},
      '{32'h1030, 8'd8,  POP_DUAL,   1'b1},
      '{32'h1100, 8'd8,  POP_STALL,  1'b0},
      '{32'h1104, 8'd6,  POP_SINGLE, 1'b1},
      '{32'h1200, 8'd20, POP_DUAL,   1'b0}
   };

   logic        clk;
   logic        reset;
   logic        restart_valid;
   addr_t       restart_pc;
   logic        restart_ack;
   logic        flush_req;
   logic        flush_complete;
   fetch_insn_t insn;
   logic        insn_valid;
   logic        insn_ack;
   fetch_insn_t insn_two;
   logic        insn_valid_two;
   logic        insn_ack_two;
   logic        mem_req_valid;
   addr_t       mem_req_addr;
   logic        mem_rsp_valid = 1'b0;
   line_t       mem_rsp_load_data = '0;

   int          errors = 0;
   int          checks = 0;
   int          flush_count = 0;
   int          ack_count = 0;
   int          cur_row = 0;
   int          allowed [addr_t];     // line -> last row whose path holds it
   addr_t       stream [$];
   addr_t       watch_line = '0;
   logic        watch_seen = 1'b0;
   logic        rsp_pending = 1'b0;
   int          rsp_wait = 0;
   addr_t       rsp_addr = '0;
   logic        model_valid [NUM_SETS];
   logic [TAG_BITS-1:0] model_tag [NUM_SETS];

   tb_clock #(.PERIOD_NS(40)) tb_clock_i
   (
      .clk (clk)
   );

   fetch_unit #(.LG_NUM_SETS(SETS_LG), .LG_FQ_ENTRIES(FQ_LG)) fetch_unit_i
   (
      .clk               (clk),
      .reset             (reset),
      .restart_valid     (restart_valid),
      .restart_pc        (restart_pc),
      .restart_ack       (restart_ack),
      .flush_req         (flush_req),
      .flush_complete    (flush_complete),
      .insn              (insn),
      .insn_valid        (insn_valid),
      .insn_ack          (insn_ack),
      .insn_two          (insn_two),
      .insn_valid_two    (insn_valid_two),
      .insn_ack_two      (insn_ack_two),
      .mem_req_valid     (mem_req_valid),
      .mem_req_addr      (mem_req_addr),
      .mem_rsp_valid     (mem_rsp_valid),
      .mem_rsp_load_data (mem_rsp_load_data)
   );

   function automatic kind_t kind_at(addr_t a);
      kind_t k;
      k = K_ADDI;
      for (int i = 0; i < N_PROG; i++)
         if (PROG_ADDR[i] == a)
            k = PROG_KIND[i];
      return k;
   endfunction

   function automatic int imm_at(addr_t a);
      int imm;
      imm = 0;
      for (int i = 0; i < N_PROG; i++)
         if (PROG_ADDR[i] == a)
            imm = PROG_IMM[i];
      return imm;
   endfunction

   function automatic logic [31:0] encode_jal(logic [4:0] rd, int imm);
      logic [20:0] im;
      im = imm[20:0];
      return {im[20], im[10:1], im[11], im[19:12], rd, 7'h6f};
   endfunction

   function automatic logic [31:0] encode_beq(int imm);
      logic [12:0] im;
      im = imm[12:0];
      return {im[12], im[10:5], 5'd2, 5'd1, 3'b000, im[4:1], im[11], 7'h63};  // beq x1, x2
   endfunction

   function automatic logic [31:0] mem_word(addr_t a);
      case (kind_at(a))
         K_J:
            return encode_jal(5'd0, imm_at(a));
         K_JAL:
            return encode_jal(5'd1, imm_at(a));
         K_BEQ:
            return encode_beq(imm_at(a));
         default:
            return {a[13:2], 5'd0, 3'b000, a[6:2], 7'h13};  // addi rd, x0, imm
      endcase
   endfunction

   function automatic logic is_jump(addr_t a);
      return (kind_at(a) == K_J) || (kind_at(a) == K_JAL);
   endfunction

   function automatic addr_t next_pc(addr_t a);
      if (is_jump(a))
         return a + addr_t'(imm_at(a));
      return a + 32'd4;
   endfunction

   function automatic addr_t line_of(addr_t a);
      return {a[31:LG_LINE_BYTES], {LG_LINE_BYTES{1'b0}}};
   endfunction

   function automatic line_t line_data(addr_t line);
      line_t d;
      for (int w = 0; w < WORDS_PER_LINE; w++)
         d[32*w +: 32] = mem_word(line + addr_t'(4 * w));
      return d;
   endfunction

   function automatic fetch_insn_t expect_entry(addr_t a);
      fetch_insn_t e;
      e.insn_bytes = mem_word(a);
      e.pc = a;
      e.pred_target = next_pc(a);
      e.pred = is_jump(a);
      return e;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_entry(input fetch_insn_t got, input int idx);
      fetch_insn_t exp;
      exp = expect_entry(stream[idx]);
      checks++;
      assert (got == exp)
      else
      begin
         errors++;
         $display("ERR %0t: pop %0d got pc %h bytes %h target %h pred %b", $time, idx,
                  got.pc, got.insn_bytes, got.pred_target, got.pred);
         $display("ERR %0t: pop %0d expected pc %h bytes %h target %h pred %b", $time, idx,
                  exp.pc, exp.insn_bytes, exp.pred_target, exp.pred);
      end
   endtask

   // memory model with request checks and a delayed line response
   task automatic note_request(input addr_t a);
      logic [SETS_LG-1:0] set;
      set = a[LG_LINE_BYTES +: SETS_LG];
      checks++;
      assert (!rsp_pending)
      else
      begin
         errors++;
         $display("a second memory request came while one was still outstanding");
      end
      checks++;
      assert (allowed.exists(a) && allowed[a] >= cur_row - 1)
      else
      begin
         errors++;
         $display("ERR %0t: memory request %h is not a line of the fetch path", $time, a);
      end
      checks++;
      assert (!(model_valid[set] && model_tag[set] == a[31 -: TAG_BITS]))
      else
      begin
         errors++;
         $display("ERR %0t: repeated memory request for cached line %h", $time, a);
      end
      if (a == watch_line)
         watch_seen = 1'b1;
      rsp_pending = 1'b1;
      rsp_addr = a;
      rsp_wait = 1 + ($urandom % 8);
   endtask

   initial
   begin
      int unsigned seed_value;
      seed_value = $urandom(RANDOM_SEED);
      forever
      begin
         @(posedge clk);
         #1;
         if (!reset)
         begin
            if (flush_complete)
            begin
               flush_count++;
               for (int s = 0; s < NUM_SETS; s++)
                  model_valid[s] = 1'b0;
            end
            if (restart_ack)
               ack_count++;
            if (mem_req_valid)
               note_request(mem_req_addr);
         end
         #1;
         mem_rsp_valid = 1'b0;
         if (rsp_pending && rsp_wait == 0)
         begin
            mem_rsp_valid = 1'b1;
            mem_rsp_load_data = line_data(rsp_addr);
            model_valid[rsp_addr[LG_LINE_BYTES +: SETS_LG]] = 1'b1;
            model_tag[rsp_addr[LG_LINE_BYTES +: SETS_LG]] = rsp_addr[31 -: TAG_BITS];
            rsp_pending = 1'b0;
         end
         else if (rsp_pending)
            rsp_wait--;
      end
   end

   task automatic run_row(input int r);
      row_t      row;
      pop_mode_t mode;
      addr_t     pc;
      int        err_start;
      int        ack_start;
      int        flush_start;
      int        k;
      int        guard;
      int        limit;
      row = ROWS[r];
      mode = row.mode;
      err_start = errors;
      cur_row = r;
      limit = 40 * int'(row.count) + WAIT_LIMIT;
      stream.delete();
      pc = row.pc;
      for (int i = 0; i < int'(row.count) + LOOKAHEAD; i++)
      begin
         stream.push_back(pc);
         allowed[line_of(pc)] = r;
         pc = next_pc(pc);
      end

      if (row.flush)
      begin
         flush_start = flush_count;
         next_cycle();
         flush_req = 1'b1;
         next_cycle();
         flush_req = 1'b0;
         guard = 0;
         while (flush_count == flush_start && guard < WAIT_LIMIT)
         begin
            next_cycle();
            guard++;
         end
         checks++;
         assert (flush_count == flush_start + 1)
         else
         begin
            errors++;
            $display("flush_complete did not pulse after the flush request of test %0d", r);
         end
         checks++;
         assert (!insn_valid)
         else
         begin
            errors++;
            $display("ERR %0t: insn_valid still high after the flush", $time);
         end
         watch_line = line_of(row.pc);
         watch_seen = 1'b0;
      end

      ack_start = ack_count;
      next_cycle();
      restart_valid = 1'b1;
      restart_pc = row.pc;
      next_cycle();
      restart_valid = 1'b0;
      guard = 0;
      while (ack_count == ack_start && guard < WAIT_LIMIT)
      begin
         next_cycle();
         guard++;
      end

      if (mode == POP_STALL)
      begin
         guard = 0;
         while (!insn_valid && guard < WAIT_LIMIT)
         begin
            next_cycle();
            guard++;
         end
         repeat (STALL_CYCLES)
         begin
            next_cycle();
            checks++;
            assert (insn_valid)
            else
            begin
               errors++;
               $display("ERR %0t: insn_valid dropped while pops were held off", $time);
            end
         end
         checks++;
         assert (insn_valid_two)
         else
         begin
            errors++;
            $display("ERR %0t: insn_valid_two low with the queue held full", $time);
         end
      end

      k = 0;
      guard = 0;
      while (k < int'(row.count) && guard < limit)
      begin
         next_cycle();
         guard++;
         insn_ack = 1'b0;
         insn_ack_two = 1'b0;
         if (mode != POP_SINGLE && insn_valid_two && int'(row.count) - k >= 2)
         begin
            check_entry(insn, k);
            check_entry(insn_two, k + 1);
            insn_ack = 1'b1;
            insn_ack_two = 1'b1;
            k += 2;
         end
         else if (insn_valid)
         begin
            check_entry(insn, k);
            insn_ack = 1'b1;
            k++;
         end
      end
      next_cycle();
      insn_ack = 1'b0;
      insn_ack_two = 1'b0;

      checks++;
      assert (k == int'(row.count))
      else
      begin
         errors++;
         $display("test %0d popped only %0d of %0d instructions in time", r, k, row.count);
      end
      checks++;
      assert (ack_count == ack_start + 1)
      else
      begin
         errors++;
         $display("ERR %0t: restart_ack pulsed %0d times for one restart", $time,
                  ack_count - ack_start);
      end
      if (row.flush)
      begin
         checks++;
         assert (watch_seen)
         else
         begin
            errors++;
            $display("no memory request for line %h after the flush", watch_line);
         end
      end

      if (errors == err_start)
         $display("test %0d: restart %h, %0d pops, %s: ok", r, row.pc, row.count, mode.name());
      else
         $display("test %0d: restart %h, %0d pops, %s: %0d errors", r, row.pc, row.count,
                  mode.name(), errors - err_start);
   endtask

   // watchdog sized from the pop counts of the table
   initial
   begin
      int total;
      int limit;
      total = 0;
      for (int i = 0; i < N_ROWS; i++)
         total += int'(ROWS[i].count);
      limit = total * 40 + 2000;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", limit);
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      int          err_start;
      for (int s = 0; s < NUM_SETS; s++)
      begin
         model_valid[s] = 1'b0;
         model_tag[s] = '0;
      end
      reset = 1'b1;
      restart_valid = 1'b0;
      restart_pc = '0;
      flush_req = 1'b0;
      insn_ack = 1'b0;
      insn_ack_two = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;

      // nothing is fetched before the first restart
      err_start = errors;
      repeat (NUM_SETS + 24)
      begin
         next_cycle();
         checks++;
         assert (!insn_valid && !mem_req_valid)
         else
         begin
            errors++;
            $display("ERR %0t: insn_valid %b mem_req_valid %b before any restart", $time,
                     insn_valid, mem_req_valid);
         end
      end
      checks++;
      assert (flush_count == 1)
      else
      begin
         errors++;
         $display("ERR %0t: flush_complete pulsed %0d times after reset", $time, flush_count);
      end
      $display("test reset: flush_complete pulses %0d, %0d errors", flush_count,
               errors - err_start);

      for (int r = 0; r < N_ROWS; r++)
         run_row(r);

      $display("%0d tests, %0d checks, %0d errors", N_ROWS + 1, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
   parameter int PERIOD_NS = 40
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*;
#(
   parameter int LG_NUM_SETS = DEF_LG_NUM_SETS,
   parameter int LG_FQ_ENTRIES = DEF_LG_FQ_ENTRIES
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        restart_valid,
   input  addr_t       restart_pc,
   output logic        restart_ack,
   input  logic        flush_req,
   output logic        flush_complete,
   output fetch_insn_t insn,
   output logic        insn_valid,
   input  logic        insn_ack,
   output fetch_insn_t insn_two,
   output logic        insn_valid_two,
   input  logic        insn_ack_two,
   output logic        mem_req_valid,
   output addr_t       mem_req_addr,
   input  logic        mem_rsp_valid,
   input  line_t       mem_rsp_load_data
);

   localparam int TAG_BITS = 32 - LG_NUM_SETS - LG_LINE_BYTES;

   logic                   miss;
   addr_t                  miss_addr;
   refill_t                refill;
   logic [LG_NUM_SETS-1:0] rd_idx;
   logic [TAG_BITS-1:0]    rd_tag;
   logic                   rd_en;
   logic                   clr_en;
   logic [LG_NUM_SETS-1:0] clr_idx;
   line_rd_t               line_rd;
   logic                   fq_full;
   logic                   push;
   fetch_insn_t            push_insn;
   logic                   fq_clear;

   line_refill line_refill_i
   (
      .clk               (clk),
      .reset             (reset),
      .miss              (miss),
      .miss_addr         (miss_addr),
      .mem_req_valid     (mem_req_valid),
      .mem_req_addr      (mem_req_addr),
      .mem_rsp_valid     (mem_rsp_valid),
      .mem_rsp_load_data (mem_rsp_load_data),
      .refill            (refill)
   );

   icache_arrays #(.LG_NUM_SETS(LG_NUM_SETS)) icache_arrays_i
   (
      .clk     (clk),
      .rd_idx  (rd_idx),
      .rd_tag  (rd_tag),
      .rd_en   (rd_en),
      .clr_en  (clr_en),
      .clr_idx (clr_idx),
      .refill  (refill),
      .line_rd (line_rd)
   );

   fetch_ctrl #(.LG_NUM_SETS(LG_NUM_SETS)) fetch_ctrl_i
   (
      .clk            (clk),
      .reset          (reset),
      .restart_valid  (restart_valid),
      .restart_pc     (restart_pc),
      .restart_ack    (restart_ack),
      .flush_req      (flush_req),
      .flush_complete (flush_complete),
      .refill         (refill),
      .rd_idx         (rd_idx),
      .rd_tag         (rd_tag),
      .rd_en          (rd_en),
      .clr_en         (clr_en),
      .clr_idx        (clr_idx),
      .line_rd        (line_rd),
      .miss           (miss),
      .miss_addr      (miss_addr),
      .fq_full        (fq_full),
      .push           (push),
      .push_insn      (push_insn),
      .fq_clear       (fq_clear)
   );

   fetch_queue #(.LG_FQ_ENTRIES(LG_FQ_ENTRIES)) fetch_queue_i
   (
      .clk            (clk),
      .reset          (reset),
      .clear          (fq_clear),
      .push           (push),
      .push_insn      (push_insn),
      .full           (fq_full),
      .insn           (insn),
      .insn_valid     (insn_valid),
      .insn_two       (insn_two),
      .insn_valid_two (insn_valid_two),
      .insn_ack       (insn_ack),
      .insn_ack_two   (insn_ack_two)
   );

endmodule

`default_nettype wire

/* design/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue import fetch_pkg::*;
#(
   parameter int LG_FQ_ENTRIES = DEF_LG_FQ_ENTRIES
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        clear,
   input  logic        push,
   input  fetch_insn_t push_insn,
   output logic        full,
   output fetch_insn_t insn,
   output logic        insn_valid,
   output fetch_insn_t insn_two,
   output logic        insn_valid_two,
   input  logic        insn_ack,
   input  logic        insn_ack_two
);

   localparam int N_ENTRIES = 1 << LG_FQ_ENTRIES;

   fetch_insn_t            r_fq [N_ENTRIES];
   logic [LG_FQ_ENTRIES:0] r_head, n_head;   // msb is the wrap bit
   logic [LG_FQ_ENTRIES:0] r_tail, n_tail;
   logic [LG_FQ_ENTRIES:0] next_head;
   logic                   empty;
   logic                   next_empty;

   always_comb
   begin
      next_head = r_head + 1'b1;
      empty = (r_head == r_tail);
      next_empty = (next_head == r_tail);
      full = (r_head[LG_FQ_ENTRIES] != r_tail[LG_FQ_ENTRIES]) &&
             (r_head[LG_FQ_ENTRIES-1:0] == r_tail[LG_FQ_ENTRIES-1:0]);
      n_tail = push ? r_tail + 1'b1 : r_tail;
      n_head = r_head;
      if (insn_ack && insn_ack_two)
         n_head = r_head + 2'd2;
      else if (insn_ack)
         n_head = next_head;
   end

   assign insn = r_fq[r_head[LG_FQ_ENTRIES-1:0]];
   assign insn_two = r_fq[next_head[LG_FQ_ENTRIES-1:0]];
   assign insn_valid = !empty;
   assign insn_valid_two = !empty && !next_empty;

   always_ff @(posedge clk)
   begin
      if (push)
         r_fq[r_tail[LG_FQ_ENTRIES-1:0]] <= push_insn;
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         r_head <= '0;
         r_tail <= '0;
      end
      else
      begin
         r_head <= n_head;
         r_tail <= n_tail;
      end
   end

endmodule

`default_nettype wire

/* design/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import fetch_pkg::*;
#(
   parameter int LG_NUM_SETS = DEF_LG_NUM_SETS,
   localparam int TAG_BITS = 32 - LG_NUM_SETS - LG_LINE_BYTES
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   restart_valid,
   input  addr_t                  restart_pc,
   output logic                   restart_ack,
   input  logic                   flush_req,
   output logic                   flush_complete,
   input  refill_t                refill,
   output logic [LG_NUM_SETS-1:0] rd_idx,
   output logic [TAG_BITS-1:0]    rd_tag,
   output logic                   rd_en,
   output logic                   clr_en,
   output logic [LG_NUM_SETS-1:0] clr_idx,
   input  line_rd_t               line_rd,
   output logic                   miss,
   output addr_t                  miss_addr,
   input  logic                   fq_full,
   output logic                   push,
   output fetch_insn_t            push_insn,
   output logic                   fq_clear
);

   fetch_state_t r_state, n_state;
   addr_t        r_pc, n_pc;             // next pc to look up
   addr_t        r_cache_pc, n_cache_pc; // pc of the lookup in flight
   addr_t        r_miss_pc, n_miss_pc;
   addr_t        r_restart_pc, n_restart_pc;
   addr_t        t_lookup_pc;
   logic         r_req, n_req;
   logic         r_bubble, n_bubble;
   logic         r_restart_req, n_restart_req;
   logic         r_flush_req, n_flush_req;
   logic         r_restart_ack, n_restart_ack;
   logic         r_flush_complete, n_flush_complete;
   logic [LG_NUM_SETS-1:0] r_clr_idx, n_clr_idx;

   logic [LG_LINE_BYTES-3:0] t_word;
   logic [31:0]  t_insn_word;
   cflow_t       t_pd;
   addr_t        t_jimm;
   addr_t        t_target;
   logic         t_take_jump;
   logic         t_hit;
   logic         t_miss;
   logic         t_do_flush;
   logic         t_do_restart;

   // word select and static jump prediction
   always_comb
   begin
      t_word = r_cache_pc[LG_LINE_BYTES-1:2];
      t_insn_word = line_rd.data[32*t_word +: 32];
      t_pd = line_rd.pd[t_word];
      t_jimm = {{11{t_insn_word[31]}}, t_insn_word[31], t_insn_word[19:12],
                t_insn_word[20], t_insn_word[30:21], 1'b0};
      t_take_jump = (t_pd == J) || (t_pd == JAL);
      t_target = t_take_jump ? r_cache_pc + t_jimm : r_cache_pc + 32'd4;
      t_hit = r_req && line_rd.hit;
      t_miss = r_req && !line_rd.hit;
      push_insn.insn_bytes = t_insn_word;
      push_insn.pc = r_cache_pc;
      push_insn.pred_target = t_target;
      push_insn.pred = t_take_jump;
   end

   always_comb
   begin
      n_state = r_state;
      n_pc = r_pc;
      n_cache_pc = r_cache_pc;
      n_miss_pc = r_miss_pc;
      n_restart_pc = restart_valid ? restart_pc : r_restart_pc;
      n_restart_req = r_restart_req | restart_valid;
      n_flush_req = r_flush_req | flush_req;
      n_restart_ack = 1'b0;
      n_flush_complete = 1'b0;
      n_req = 1'b0;
      n_bubble = 1'b0;
      n_clr_idx = r_clr_idx;
      t_lookup_pc = r_pc;
      t_do_flush = 1'b0;
      t_do_restart = 1'b0;
      clr_en = 1'b0;
      miss = 1'b0;
      push = 1'b0;
      fq_clear = 1'b0;
      case (r_state)
         INITIALIZE:
         begin
            n_clr_idx = '0;
            n_state = FLUSH_CACHE;
         end
         FLUSH_CACHE:
         begin
            clr_en = 1'b1;
            n_clr_idx = r_clr_idx + 1'b1;
            if (&r_clr_idx)      // last set
            begin
               n_flush_complete = 1'b1;
               n_state = IDLE;
            end
         end
         IDLE:
            t_do_restart = n_restart_req;
         ACTIVE:
         begin
            n_req = 1'b1;
            n_cache_pc = r_pc;
            n_pc = r_pc + 32'd4;
            if (r_bubble)
            begin
               // fall-through result after a jump is dropped
            end
            else if (n_flush_req || n_restart_req)
            begin
               t_do_flush = n_flush_req;
               t_do_restart = n_restart_req;
            end
            else if (t_miss)
            begin
               miss = 1'b1;
               n_miss_pc = r_cache_pc;
               n_pc = r_pc;
               n_state = INJECT_RELOAD;
            end
            else if (t_hit && fq_full)
            begin
               n_miss_pc = r_cache_pc;   // replayed once the queue drains
               n_pc = r_pc;
               n_state = WAIT_FOR_NOT_FULL;
            end
            else if (t_hit)
            begin
               push = 1'b1;
               if (t_take_jump)
               begin
                  n_pc = t_target;
                  n_bubble = 1'b1;
               end
            end
         end
         INJECT_RELOAD:
         begin
            if (refill.valid)
               n_state = RELOAD_TURNAROUND;
         end
         RELOAD_TURNAROUND:
         begin
            t_lookup_pc = r_miss_pc;
            if (n_flush_req || n_restart_req)
            begin
               t_do_flush = n_flush_req;
               t_do_restart = n_restart_req;
            end
            else if (!fq_full)
            begin
               n_req = 1'b1;
               n_cache_pc = r_miss_pc;
               n_state = ACTIVE;
            end
         end
         WAIT_FOR_NOT_FULL:
         begin
            t_lookup_pc = r_miss_pc;
            if (!fq_full)
            begin
               n_req = 1'b1;
               n_cache_pc = r_miss_pc;
               n_state = ACTIVE;
            end
            else
            begin
               t_do_flush = n_flush_req;
               t_do_restart = n_restart_req;
            end
         end
         default:
            n_state = INITIALIZE;
      endcase

      // flush wins over a restart pending in the same cycle
      if (t_do_flush)
      begin
         n_flush_req = 1'b0;
         fq_clear = 1'b1;
         n_clr_idx = '0;
         n_req = 1'b0;
         n_bubble = 1'b0;
         n_state = FLUSH_CACHE;
      end
      else if (t_do_restart)
      begin
         n_restart_req = 1'b0;
         n_restart_ack = 1'b1;
         fq_clear = 1'b1;
         n_pc = n_restart_pc;
         n_req = 1'b0;
         n_bubble = 1'b0;
         n_state = ACTIVE;
      end
   end

   assign rd_idx = t_lookup_pc[LG_LINE_BYTES +: LG_NUM_SETS];
   assign rd_tag = t_lookup_pc[31 -: TAG_BITS];
   assign rd_en = n_req;
   assign clr_idx = r_clr_idx;
   assign miss_addr = r_cache_pc;
   assign restart_ack = r_restart_ack;
   assign flush_complete = r_flush_complete;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= INITIALIZE;
         r_pc <= '0;
         r_cache_pc <= '0;
         r_miss_pc <= '0;
         r_req <= 1'b0;
         r_bubble <= 1'b0;
         r_restart_req <= 1'b0;
         r_flush_req <= 1'b0;
         r_restart_ack <= 1'b0;
         r_flush_complete <= 1'b0;
         r_clr_idx <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_pc <= n_pc;
         r_cache_pc <= n_cache_pc;
         r_miss_pc <= n_miss_pc;
         r_req <= n_req;
         r_bubble <= n_bubble;
         r_restart_req <= n_restart_req;
         r_flush_req <= n_flush_req;
         r_restart_ack <= n_restart_ack;
         r_flush_complete <= n_flush_complete;
         r_clr_idx <= n_clr_idx;
      end
   end

   always_ff @(posedge clk)
   begin
      r_restart_pc <= n_restart_pc;
   end

endmodule

`default_nettype wire

/* design/icache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_arrays import fetch_pkg::*;
#(
   parameter int LG_NUM_SETS = DEF_LG_NUM_SETS,
   localparam int TAG_BITS = 32 - LG_NUM_SETS - LG_LINE_BYTES
)
(
   input  logic                   clk,
   input  logic [LG_NUM_SETS-1:0] rd_idx,
   input  logic [TAG_BITS-1:0]    rd_tag,
   input  logic                   rd_en,
   input  logic                   clr_en,
   input  logic [LG_NUM_SETS-1:0] clr_idx,
   input  refill_t                refill,
   output line_rd_t               line_rd
);

   localparam int NUM_SETS = 1 << LG_NUM_SETS;

   logic [NUM_SETS-1:0]         r_valid;
   logic [TAG_BITS-1:0]         r_tag_arr [NUM_SETS];
   line_t                       r_data_arr [NUM_SETS];
   cflow_t [WORDS_PER_LINE-1:0] r_pd_arr [NUM_SETS];

   logic [LG_NUM_SETS-1:0]      wr_idx;
   logic [TAG_BITS-1:0]         wr_tag;

   // registered read side
   logic                        r_rd_en;
   logic [TAG_BITS-1:0]         r_rd_tag;
   logic                        r_valid_out;
   logic [TAG_BITS-1:0]         r_tag_out;
   line_t                       r_data_out;
   cflow_t [WORDS_PER_LINE-1:0] r_pd_out;

   assign wr_idx = refill.line_addr[LG_LINE_BYTES +: LG_NUM_SETS];
   assign wr_tag = refill.line_addr[31 -: TAG_BITS];

   always_ff @(posedge clk)
   begin
      if (clr_en)
         r_valid[clr_idx] <= 1'b0;
      if (refill.valid)
         r_valid[wr_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (refill.valid)
      begin
         r_tag_arr[wr_idx] <= wr_tag;
         r_data_arr[wr_idx] <= refill.data;
         r_pd_arr[wr_idx] <= refill.pd;
      end
   end

   always_ff @(posedge clk)
   begin
      r_rd_en <= rd_en;
      r_rd_tag <= rd_tag;
      r_valid_out <= r_valid[rd_idx];
      r_tag_out <= r_tag_arr[rd_idx];
      r_data_out <= r_data_arr[rd_idx];
      r_pd_out <= r_pd_arr[rd_idx];
   end

   assign line_rd = '{
      hit:  r_rd_en && r_valid_out && (r_tag_out == r_rd_tag),
      data: r_data_out,
      pd:   r_pd_out
   };

endmodule

`default_nettype wire

/* design/line_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module line_refill import fetch_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    miss,
   input  addr_t   miss_addr,
   output logic    mem_req_valid,
   output addr_t   mem_req_addr,
   input  logic    mem_rsp_valid,
   input  line_t   mem_rsp_load_data,
   output refill_t refill
);

   logic                        r_req_valid;
   addr_t                       r_req_addr;
   cflow_t [WORDS_PER_LINE-1:0] line_pd;

   always_ff @(posedge clk)
   begin
      if (reset)
         r_req_valid <= 1'b0;
      else
         r_req_valid <= miss;
   end

   // line address is held until the response comes back
   always_ff @(posedge clk)
   begin
      if (miss)
         r_req_addr <= {miss_addr[31:LG_LINE_BYTES], {LG_LINE_BYTES{1'b0}}};
   end

   assign mem_req_valid = r_req_valid;
   assign mem_req_addr = r_req_addr;

   for (genvar i = 0; i < WORDS_PER_LINE; i++)
   begin : g_pd
      predecode predecode_i
      (
         .insn (mem_rsp_load_data[32*i +: 32]),
         .pd   (line_pd[i])
      );
   end

   assign refill = '{
      valid:     mem_rsp_valid,
      line_addr: r_req_addr,
      data:      mem_rsp_load_data,
      pd:        line_pd
   };

endmodule

`default_nettype wire

/* design/predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module predecode import fetch_pkg::*;
(
   input  logic [31:0] insn,
   output cflow_t      pd
);

   logic [6:0] opcode;
   logic [4:0] rd;
   logic [4:0] rs1;
   logic       rd_link;
   logic       rs1_link;

   assign opcode = insn[6:0];
   assign rd = insn[11:7];
   assign rs1 = insn[19:15];
   assign rd_link = (rd == 5'd1) || (rd == 5'd5);    // ra or t0
   assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

   always_comb
   begin
      pd = NOT_CFLOW;
      case (opcode)
         7'h63:
            pd = COND_BR;
         7'h67:
         begin
            if (rd != 5'd0)
               pd = JALR;
            else if (rs1_link)
               pd = RET;
            else
               pd = JR;
         end
         7'h6f:
         begin
            if (rd_link)
               pd = JAL;
            else
               pd = J;
         end
         default:
            pd = NOT_CFLOW;
      endcase
   end

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

   typedef logic [31:0] addr_t;

   localparam int WORDS_PER_LINE = 4;
   localparam int LG_LINE_BYTES = 4;

   typedef logic [32*WORDS_PER_LINE-1:0] line_t;

   // control-flow class of one instruction word
   typedef enum logic [2:0] {
      NOT_CFLOW = 3'd0,
      COND_BR   = 3'd1,
      RET       = 3'd2,
      J         = 3'd3,
      JR        = 3'd4,
      JAL       = 3'd5,
      JALR      = 3'd6
   } cflow_t;

   typedef enum logic [2:0] {
      INITIALIZE        = 3'd0,
      FLUSH_CACHE       = 3'd1,
      IDLE              = 3'd2,
      ACTIVE            = 3'd3,
      INJECT_RELOAD     = 3'd4,
      RELOAD_TURNAROUND = 3'd5,
      WAIT_FOR_NOT_FULL = 3'd6
   } fetch_state_t;

   typedef struct packed {
      logic [31:0] insn_bytes;
      addr_t       pc;
      addr_t       pred_target;
      logic        pred;
   } fetch_insn_t;

   typedef struct packed {
      logic                             valid;      // array write strobe
      addr_t                            line_addr;
      line_t                            data;
      cflow_t [WORDS_PER_LINE-1:0]      pd;
   } refill_t;

   typedef struct packed {
      logic                             hit;
      line_t                            data;
      cflow_t [WORDS_PER_LINE-1:0]      pd;
   } line_rd_t;

   localparam int DEF_LG_NUM_SETS = 4;
   localparam int DEF_LG_FQ_ENTRIES = 3;

endpackage

`default_nettype wire
